/* src/snake_pkg.sv */
// Shared types for the snake game core
// Grid points, headings, game states and the move strobe payload
package snake_pkg;

    // --------------------
    // Grid geometry
    // --------------------

    // One bit wider than the grid needs, so a step off the edge stays visible
    typedef logic [6:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } point_t;

    // Clockwise order, so a right turn is +1 and a left turn is -1
    typedef enum logic [1:0] {
        dir_up    = 2'd0,
        dir_right = 2'd1,
        dir_down  = 2'd2,
        dir_left  = 2'd3
    } heading_t;

    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_play = 2'd1,
        st_over = 2'd2
    } game_state_t;

    // Payload of one step
    typedef struct packed {
        point_t   head;
        heading_t heading;
    } move_t;

    // --------------------
    // Heading helpers
    // --------------------

    function automatic heading_t rotate_cw(input heading_t h);
        return heading_t'(2'(h + 2'd1));
    endfunction

    function automatic heading_t rotate_ccw(input heading_t h);
        return heading_t'(2'(h - 2'd1));
    endfunction

    // No wraparound, y grows downwards
    function automatic point_t step_point(input point_t p, input heading_t h);
        point_t n;
        n = p;
        case (h)
            dir_up:    n.y = p.y - coord_t'(1);
            dir_right: n.x = p.x + coord_t'(1);
            dir_down:  n.y = p.y + coord_t'(1);
            default:   n.x = p.x - coord_t'(1);
        endcase
        return n;
    endfunction

endpackage

/* src/head_stepper.sv */
// Button front end and step generator
// Synchronizes the turn buttons, keeps one pending turn per step and
// emits a move strobe with the next head every TICK_CYCLES clocks
module head_stepper #(
    parameter int TICK_CYCLES = 6_250_000
) (
    input  logic              clock_25,
    input  logic              rst,
    input  logic              right_p,
    input  logic              left_p,
    input  logic              playing,
    input  snake_pkg::point_t start_head,
    output logic              start_press,
    output snake_pkg::move_t  move,
    output logic              move_valid
);
    import snake_pkg::*;

    localparam int CNT_BITS = (TICK_CYCLES > 1) ? $clog2(TICK_CYCLES) : 1;

    // Bit 1 is right, bit 0 is left
    logic [1:0]          sync_a;
    logic [1:0]          sync_b;
    logic [1:0]          sync_prev;
    logic [1:0]          press;
    logic                turn_pending;
    logic                turn_right;
    logic [CNT_BITS-1:0] tick_cnt;
    logic                tick;
    heading_t            next_heading;

    // --------------------
    // Button synchronizers
    // --------------------
    always_ff @(posedge clock_25) begin
        if (rst) begin
            sync_a    <= '0;
            sync_b    <= '0;
            sync_prev <= '0;
            press     <= '0;
        end else begin
            sync_a    <= {right_p, left_p};
            sync_b    <= sync_a;
            sync_prev <= sync_b;
            press     <= sync_b & ~sync_prev;
        end
    end

    // Outside play a press only means start
    assign start_press = (|press) && !playing;

    // Only the first press between two ticks is kept
    always_ff @(posedge clock_25) begin
        if (rst) begin
            turn_pending <= 1'b0;
            turn_right   <= 1'b0;
        end else if (tick) begin
            turn_pending <= 1'b0;
        end else if (playing && !turn_pending && (|press)) begin
            turn_pending <= 1'b1;
            turn_right   <= press[1];
        end
    end

    always_comb begin
        next_heading = move.heading;
        if (turn_pending) begin
            next_heading = turn_right ? rotate_cw(move.heading) : rotate_ccw(move.heading);
        end
    end

    // --------------------
    // Step timing
    // --------------------
    assign tick = playing && (tick_cnt == CNT_BITS'(TICK_CYCLES - 1));

    always_ff @(posedge clock_25) begin
        if (rst || !playing || tick) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    // move.head doubles as the current head of the stepper
    always_ff @(posedge clock_25) begin
        if (rst) begin
            move       <= '{head: start_head, heading: dir_right};
            move_valid <= 1'b0;
        end else begin
            move_valid <= tick;
            if (tick) begin
                move <= '{head: step_point(move.head, next_heading), heading: next_heading};
            end
        end
    end

endmodule

/* src/snake_body.sv */
// Snake body store
// Ring of segment points with the newest at head_ptr; the last
// length entries are the body. Flags a new head landing on the body
module snake_body #(
    parameter int MAX_LEN  = 63,
    parameter int LEN_BITS = 6,
    parameter int GRID_W   = 32,
    parameter int GRID_H   = 32
) (
    input  logic                clock_25,
    input  logic                rst,
    input  snake_pkg::move_t    move,
    input  logic                move_valid,
    input  logic                grow,
    input  logic                playing,
    output logic                body_hit,
    output logic [LEN_BITS-1:0] length,
    output snake_pkg::point_t   head_out,
    output snake_pkg::point_t   start_head
);
    import snake_pkg::*;

    localparam point_t CENTER = '{x: coord_t'(GRID_W / 2), y: coord_t'(GRID_H / 2)};

    point_t              seg [MAX_LEN];
    logic [LEN_BITS-1:0] head_ptr;
    logic [LEN_BITS-1:0] nxt_ptr;
    logic [MAX_LEN-1:0]  hit_vec;
    logic                accept;

    // Referee holds playing low on a colliding move
    assign accept  = move_valid && playing;
    assign nxt_ptr = (head_ptr == LEN_BITS'(MAX_LEN - 1)) ? '0 : head_ptr + 1'b1;

    // --------------------
    // Self-hit compare
    // --------------------
    always_comb begin
        logic [LEN_BITS:0] age;
        hit_vec = '0;
        for (int i = 0; i < MAX_LEN; i++) begin
            // Distance back from the newest segment
            if (head_ptr >= LEN_BITS'(i)) begin
                age = {1'b0, head_ptr} - (LEN_BITS + 1)'(i);
            end else begin
                age = {1'b0, head_ptr} + (LEN_BITS + 1)'(MAX_LEN - i);
            end
            hit_vec[i] = (age < {1'b0, length}) && (seg[i] == move.head);
        end
    end

    assign body_hit = |hit_vec;

    // --------------------
    // Segment ring
    // --------------------
    always_ff @(posedge clock_25) begin
        if (rst) begin
            seg[0] <= CENTER;
        end else if (accept) begin
            seg[nxt_ptr] <= move.head;
        end
    end

    // Tail follows on its own unless the length grows
    always_ff @(posedge clock_25) begin
        if (rst) begin
            head_ptr <= '0;
            length   <= LEN_BITS'(1);
        end else if (accept) begin
            head_ptr <= nxt_ptr;
            if (grow && (length != LEN_BITS'(MAX_LEN))) begin
                length <= length + 1'b1;
            end
        end
    end

    assign head_out   = seg[head_ptr];
    assign start_head = CENTER;

endmodule

/* src/game_referee.sv */
// Game referee
// Runs the idle, play and over FSM, judges each move against the walls,
// the body and the fruit, keeps the score and places new fruit
module game_referee #(
    parameter int GRID_W = 32,
    parameter int GRID_H = 32
) (
    input  logic                   clock_25,
    input  logic                   rst,
    input  logic                   start_press,
    input  snake_pkg::move_t       move,
    input  logic                   move_valid,
    input  logic                   body_hit,
    output logic                   grow,
    output logic                   playing,
    output snake_pkg::game_state_t state,
    output snake_pkg::point_t      fruit,
    output logic [7:0]             score
);
    import snake_pkg::*;

    localparam logic [15:0] LFSR_SEED = 16'hace1;
    localparam coord_t      MASK_X    = coord_t'(GRID_W - 1);
    localparam coord_t      MASK_Y    = coord_t'(GRID_H - 1);

    logic [15:0] lfsr;
    logic        wall_hit;
    logic        collide;
    logic        eat;
    logic        accept;

    // Low bits of each LFSR byte, masked to the grid
    function automatic point_t fruit_from(input logic [15:0] v);
        point_t p;
        p.x = coord_t'(v[6:0]) & MASK_X;
        p.y = coord_t'(v[14:8]) & MASK_Y;
        return p;
    endfunction

    // --------------------
    // Move judging
    // --------------------

    // Below zero shows up as all ones, so one compare covers both sides
    assign wall_hit = (int'(move.head.x) >= GRID_W) || (int'(move.head.y) >= GRID_H);
    assign collide  = move_valid && (wall_hit || body_hit);
    assign eat      = (move.head == fruit);

    // Dropped already in the colliding cycle so the body skips the move
    assign playing = (state == st_play) && !collide;
    assign accept  = move_valid && playing;
    assign grow    = accept && eat;

    // --------------------
    // Game FSM
    // --------------------
    always_ff @(posedge clock_25) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (start_press) begin
                        state <= st_play;
                    end
                end
                st_play: begin
                    if (collide) begin
                        state <= st_over;
                    end
                end
                default: begin
                    // Over holds until rst
                    state <= st_over;
                end
            endcase
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1, free running
    always_ff @(posedge clock_25) begin
        if (rst) begin
            lfsr <= LFSR_SEED;
        end else begin
            lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        end
    end

    // --------------------
    // Score and fruit
    // --------------------
    always_ff @(posedge clock_25) begin
        if (rst) begin
            score <= 8'd0;
            fruit <= fruit_from(LFSR_SEED);
        end else if (grow) begin
            if (score != 8'hff) begin
                score <= score + 8'd1;
            end
            fruit <= fruit_from(lfsr);
        end
    end

endmodule

/* src/snake_game.sv */
// Snake game core top level
// Stepper produces moves, body stores them, referee judges them.
// Grid size, capacity and step period are set here and passed down
module snake_game #(
    parameter int GRID_W      = 32,
    parameter int GRID_H      = 32,
    parameter int MAX_LEN     = 63,
    parameter int TICK_CYCLES = 6_250_000,
    parameter int LEN_BITS    = 6
) (
    input  logic                   clock_25,
    input  logic                   rst,
    input  logic                   right_p,
    input  logic                   left_p,
    output snake_pkg::point_t      head_out,
    output snake_pkg::point_t      fruit,
    output logic [LEN_BITS-1:0]    length,
    output logic [7:0]             score,
    output snake_pkg::game_state_t state,
    output logic                   move_valid
);
    import snake_pkg::*;

    move_t  move;
    point_t start_head;
    logic   start_press;
    logic   playing;
    logic   grow;
    logic   body_hit;

    head_stepper #(
        .TICK_CYCLES(TICK_CYCLES)
    ) u_stepper (
        .clock_25    (clock_25),
        .rst         (rst),
        .right_p     (right_p),
        .left_p      (left_p),
        .playing     (playing),
        .start_head  (start_head),
        .start_press (start_press),
        .move        (move),
        .move_valid  (move_valid)
    );

    snake_body #(
        .MAX_LEN  (MAX_LEN),
        .LEN_BITS (LEN_BITS),
        .GRID_W   (GRID_W),
        .GRID_H   (GRID_H)
    ) u_body (
        .clock_25   (clock_25),
        .rst        (rst),
        .move       (move),
        .move_valid (move_valid),
        .grow       (grow),
        .playing    (playing),
        .body_hit   (body_hit),
        .length     (length),
        .head_out   (head_out),
        .start_head (start_head)
    );

    game_referee #(
        .GRID_W (GRID_W),
        .GRID_H (GRID_H)
    ) u_referee (
        .clock_25    (clock_25),
        .rst         (rst),
        .start_press (start_press),
        .move        (move),
        .move_valid  (move_valid),
        .body_hit    (body_hit),
        .grow        (grow),
        .playing     (playing),
        .state       (state),
        .fruit       (fruit),
        .score       (score)
    );

endmodule

/* tests/snake_game_checker.sv */
// Concurrent assertions on the snake game core
// Bound into the top level from the testbench; failures count in fail_count
module snake_game_checker #(
    parameter int GRID_W   = 32,
    parameter int GRID_H   = 32,
    parameter int LEN_BITS = 6
) (
    input logic                   clock_25,
    input logic                   rst,
    input logic                   move_valid,
    input snake_pkg::game_state_t state,
    input snake_pkg::point_t      fruit,
    input logic [LEN_BITS-1:0]    length
);
    timeunit 1ns;
    timeprecision 100ps;

    import snake_pkg::*;

    int fail_count = 0;

    a_move_in_play: assert property (@(posedge clock_25) disable iff (rst)
        move_valid |-> state == st_play)
    else begin
        fail_count++;
        $error("move strobe outside the play state");
    end

    a_length_grows: assert property (@(posedge clock_25) disable iff (rst)
        length >= $past(length))
    else begin
        fail_count++;
        $error("length decreased without reset");
    end

    a_fruit_on_grid: assert property (@(posedge clock_25) disable iff (rst)
        (int'(fruit.x) < GRID_W) && (int'(fruit.y) < GRID_H))
    else begin
        fail_count++;
        $error("fruit outside the grid");
    end

    // Over is final until reset
    a_over_holds: assert property (@(posedge clock_25) disable iff (rst)
        state == st_over |=> state == st_over)
    else begin
        fail_count++;
        $error("state left over without reset");
    end

endmodule

/* tests/snake_game_tb.sv */
// Testbench for the snake game core
// Plays several games with LFSR-chosen button presses and checks every
// move against a model of heading, head, body, length and score
module snake_game_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import snake_pkg::*;

    localparam int GRID        = 16;
    localparam int TICK        = 16;
    localparam int MAX_LEN     = 63;
    localparam int NUM_GAMES   = 10;
    localparam int MAX_STEPS   = 200;
    localparam int WATCHDOG_NS = NUM_GAMES * (MAX_STEPS * TICK + 300) * 20;

    logic        clock_25 = 1'b0;
    logic        rst;
    logic        right_p;
    logic        left_p;
    point_t      head_out;
    point_t      fruit;
    logic [5:0]  length;
    logic [7:0]  score;
    game_state_t state;
    logic        move_valid;

    logic [31:0] lfsr_state = 32'hc81d_cc69;
    int          errors = 0;
    int          games_passed = 0;
    int          games_failed = 0;

    // Model of the snake, newest segment first
    int heading;
    int hx;
    int hy;
    int mlen;
    int mscore;
    int bx[$];
    int by[$];

    snake_game #(
        .GRID_W      (GRID),
        .GRID_H      (GRID),
        .MAX_LEN     (MAX_LEN),
        .TICK_CYCLES (TICK)
    ) u_dut (
        .clock_25   (clock_25),
        .rst        (rst),
        .right_p    (right_p),
        .left_p     (left_p),
        .head_out   (head_out),
        .fruit      (fruit),
        .length     (length),
        .score      (score),
        .state      (state),
        .move_valid (move_valid)
    );

    bind snake_game snake_game_checker #(
        .GRID_W   (GRID_W),
        .GRID_H   (GRID_H),
        .LEN_BITS (LEN_BITS)
    ) u_checker (
        .clock_25   (clock_25),
        .rst        (rst),
        .move_valid (move_valid),
        .state      (state),
        .fruit      (fruit),
        .length     (length)
    );

    always #10 clock_25 = ~clock_25;

    // --------------------
    // Helpers
    // --------------------
    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
            v = (v << 1) | int'(lfsr_state[0]);
        end
        return v;
    endfunction

    // 0 keeps the heading, 1 is a right turn, 2 a left turn
    function automatic int steer_turn(input int h, input int x, input int y,
                                      input int fx, input int fy);
        int want;
        if (fx != x) begin
            want = (fx > x) ? 1 : 3;
        end else begin
            want = (fy > y) ? 2 : 0;
        end
        if (want == h) return 0;
        if (want == (h + 3) % 4) return 2;
        return 1;
    endfunction

    task automatic next_cycle();
        @(posedge clock_25);
        #2;
    endtask

    task automatic report_mismatch(input string name, input int got, input int exp);
        errors++;
        $display("ERROR %0d ns: %s expected %0d got %0d", $time, name, exp, got);
    endtask

    task automatic report_point(input string name, input point_t got, input int ex, input int ey);
        errors++;
        $display("ERROR %0d ns: %s expected (%0d,%0d) got (%0d,%0d)",
                 $time, name, ex, ey, got.x, got.y);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("Failure at %0d ns: %s", $time, what);
    endtask

    task automatic plan_presses(output int p1_at, output int p1_btn,
                                output int p2_at, output int p2_btn);
        int mode;
        p1_at  = 0;
        p1_btn = 0;
        p2_at  = 0;
        p2_btn = 0;
        mode   = rand_bits(2);
        if (mode == 1 || mode == 2) begin
            p1_btn = steer_turn(heading, hx, hy, int'(fruit.x), int'(fruit.y));
            p1_at  = 2 + rand_bits(2);
        end else if (mode == 3) begin
            p1_btn = 1 + rand_bits(1);
            p1_at  = 2 + rand_bits(2);
            p2_btn = 1 + rand_bits(1);
            p2_at  = p1_at + 2 + rand_bits(1);
        end
        // Second press of a step is ignored
        if (p1_btn == 1) begin
            heading = (heading + 1) % 4;
        end else if (p1_btn == 2) begin
            heading = (heading + 3) % 4;
        end
    endtask

    // --------------------
    // Game phases
    // --------------------
    task automatic reset_and_idle();
        rst     = 1'b1;
        right_p = 1'b0;
        left_p  = 1'b0;
        repeat (16) next_cycle();
        rst = 1'b0;
        repeat (8) begin
            next_cycle();
            if (state !== st_idle) report_mismatch("state", int'(state), int'(st_idle));
            if (int'(length) != 1) report_mismatch("length", int'(length), 1);
            if (int'(score) != 0) report_mismatch("score", int'(score), 0);
            if (move_valid !== 1'b0) report_failure("move strobe while idle");
            if (int'(head_out.x) != GRID / 2 || int'(head_out.y) != GRID / 2) begin
                report_point("head_out", head_out, GRID / 2, GRID / 2);
            end
        end
    endtask

    task automatic check_game_over();
        repeat (3 * TICK) begin
            next_cycle();
            // Presses in over must not restart anything
            right_p = (rand_bits(3) == 0);
            if (move_valid !== 1'b0) report_failure("move strobe after the game ended");
            if (state !== st_over) report_mismatch("state", int'(state), int'(st_over));
            if (int'(length) != mlen) report_mismatch("length", int'(length), mlen);
            if (int'(head_out.x) != hx || int'(head_out.y) != hy) begin
                report_point("head_out", head_out, hx, hy);
            end
        end
        right_p = 1'b0;
    endtask

    task automatic judge_move(output bit ended);
        int nx;
        int ny;
        int fx0;
        int fy0;
        bit hit;
        bit eat;
        nx  = hx;
        ny  = hy;
        fx0 = int'(fruit.x);
        fy0 = int'(fruit.y);
        case (heading)
            0: ny = ny - 1;
            1: nx = nx + 1;
            2: ny = ny + 1;
            default: nx = nx - 1;
        endcase
        hit = (nx < 0) || (nx >= GRID) || (ny < 0) || (ny >= GRID);
        foreach (bx[i]) begin
            if (bx[i] == nx && by[i] == ny) hit = 1'b1;
        end
        eat = !hit && (nx == fx0) && (ny == fy0);
        if (!hit) begin
            hx = nx;
            hy = ny;
            bx.push_front(nx);
            by.push_front(ny);
            if (eat && mlen < MAX_LEN) begin
                mlen++;
            end else begin
                void'(bx.pop_back());
                void'(by.pop_back());
            end
            if (eat && mscore < 255) mscore++;
        end
        next_cycle();
        if (hit && state !== st_over) report_mismatch("state", int'(state), int'(st_over));
        if (!hit && state !== st_play) report_mismatch("state", int'(state), int'(st_play));
        if (int'(head_out.x) != hx || int'(head_out.y) != hy) begin
            report_point("head_out", head_out, hx, hy);
        end
        if (int'(length) != mlen) report_mismatch("length", int'(length), mlen);
        if (int'(score) != mscore) report_mismatch("score", int'(score), mscore);
        // Fruit only moves when it is eaten
        if (!eat && (int'(fruit.x) != fx0 || int'(fruit.y) != fy0)) begin
            report_point("fruit", fruit, fx0, fy0);
        end
        ended = hit;
        if (hit) check_game_over();
    endtask

    task automatic play_game(input int g);
        int cyc;
        int steps;
        int waited;
        int err0;
        int p1_at;
        int p1_btn;
        int p2_at;
        int p2_btn;
        bit ended;
        err0 = errors;
        reset_and_idle();
        if (rand_bits(1)) begin
            right_p = 1'b1;
        end else begin
            left_p = 1'b1;
        end
        next_cycle();
        right_p = 1'b0;
        left_p  = 1'b0;
        waited  = 1;
        while (state !== st_play && waited < 10) begin
            next_cycle();
            waited++;
        end
        ended = (state !== st_play);
        if (ended) report_failure("game did not start after a press in idle");
        heading = 1;
        hx      = GRID / 2;
        hy      = GRID / 2;
        mlen    = 1;
        mscore  = 0;
        bx      = '{GRID / 2};
        by      = '{GRID / 2};
        steps   = 0;
        cyc     = 0;
        plan_presses(p1_at, p1_btn, p2_at, p2_btn);
        while (!ended && steps < MAX_STEPS) begin
            next_cycle();
            cyc++;
            right_p = (cyc == p1_at && p1_btn == 1) || (cyc == p2_at && p2_btn == 1);
            left_p  = (cyc == p1_at && p1_btn == 2) || (cyc == p2_at && p2_btn == 2);
            if (move_valid === 1'b1) begin
                steps++;
                if (cyc != TICK) report_mismatch("move_valid period", cyc, TICK);
                judge_move(ended);
                cyc = 1;
                plan_presses(p1_at, p1_btn, p2_at, p2_btn);
            end else if (cyc > 2 * TICK) begin
                report_failure("no move strobe within two step periods");
                ended = 1'b1;
            end
        end
        if (errors == err0) begin
            games_passed++;
        end else begin
            games_failed++;
        end
        $display("Game %0d %s: %0d steps, length %0d, score %0d, %s", g,
                 (errors == err0) ? "passed" : "failed", steps, mlen, mscore,
                 ended ? "ended" : "stopped at the step limit");
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        rst     = 1'b1;
        right_p = 1'b0;
        left_p  = 1'b0;
        for (int g = 0; g < NUM_GAMES; g++) begin
            play_game(g);
        end
        if (u_dut.u_checker.fail_count != 0) begin
            report_failure("assertions in the checker failed");
        end
        $display("Games passed %0d, failed %0d, errors %0d", games_passed, games_failed, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before all games finished");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* snake_game.f */
src/snake_pkg.sv
src/head_stepper.sv
src/snake_body.sv
src/game_referee.sv
src/snake_game.sv
tests/snake_game_checker.sv
tests/snake_game_tb.sv

/* Makefile */
# Verilator build and run for the snake game core
# make        builds and runs, pass is decided from the log
# make lint   lints the design and testbench
# make clean  removes build output and log

VERILATOR   ?= verilator
TOP         ?= snake_game_tb
FILELIST    ?= snake_game.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
TIMESCALE   ?= 1ns/100ps
ERROR_LIMIT ?= 100
VFLAGS      ?= --binary --timing --assert -j 0
LINT_FLAGS  ?= --lint-only -Wall --timing
PASS_TEXT   := ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) +verilator+error+limit+$(ERROR_LIMIT) | tee $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --timescale $(TIMESCALE) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
